// ==== Bender.yml ====
package:
  name: v33_core

sources:
  - common/v33_pkg.sv
  - hdl/instr_decode.sv
  - hdl/register_file.sv
  - hdl/alu.sv
  - execute/execute_control.sv
  - hdl/v33_core.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/v33_core_properties.sv
      - tests/tb_v33_core.sv

// ==== common/v33_pkg.sv ====
`default_nettype none

package v33_pkg;

    localparam int FETCH_BYTES = 3;  // Code bytes seen by the decoder per fetch

    typedef logic [15:0] word_t;

    localparam word_t STRING_STEP = 16'd2;  // Word string element
    localparam word_t RESET_PC = 16'h0000;

    // V33 register order
    typedef enum logic [2:0] {
        AW,
        CW,
        DW,
        BW,
        SP,
        BP,
        IX,
        IY
    } reg_index_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_CMP
    } alu_op_e;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_MOV_IMM,
        OP_ALU,
        OP_B_COND,
        OP_FLAG,
        OP_REP_PREFIX,
        OP_STM,
        OP_LDM,
        OP_MOVBK,
        OP_HALT
    } op_e;

    // Order follows opcode bits {2, 0} of F8/F9/FC/FD
    typedef enum logic [1:0] {
        FLAG_CLR_CY,
        FLAG_SET_CY,
        FLAG_CLR_DIR,
        FLAG_SET_DIR
    } flag_action_e;

    typedef struct packed {
        logic cy;
        logic p;
        logic z;
        logic s;
        logic v;
        logic dir;
    } flags_t;

    typedef struct packed {
        op_e          op;
        alu_op_e      alu_op;
        reg_index_e   reg0;         // ModRM reg or B8+r
        reg_index_e   reg1;         // ModRM rm
        word_t        imm;          // imm16 or sign extended rel8
        logic [3:0]   cond;
        flag_action_e flag_action;
        logic [1:0]   size;         // 1 to 3 bytes
    } decode_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  write;
    } mem_cmd_t;

endpackage

`default_nettype wire

// ==== execute/execute_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_control (
    input  logic                clk,
    input  logic                reset,
    input  v33_pkg::decode_t    decoded,
    input  v33_pkg::word_t      rd_a,
    input  v33_pkg::word_t      rd_b,
    input  v33_pkg::word_t      aw,
    input  v33_pkg::word_t      cw,
    input  v33_pkg::word_t      ix,
    input  v33_pkg::word_t      iy,
    input  v33_pkg::word_t      alu_result,
    input  v33_pkg::flags_t     alu_flags,
    input  logic                mem_ready,
    input  v33_pkg::word_t      mem_rdata,
    output v33_pkg::word_t      fetch_addr,
    output v33_pkg::reg_index_e rd_a_sel,
    output v33_pkg::reg_index_e rd_b_sel,
    output logic                wr_en,
    output v33_pkg::reg_index_e wr_sel,
    output v33_pkg::word_t      wr_data,
    output logic                step_ix,
    output logic                step_iy,
    output logic                dec_cw,
    output v33_pkg::alu_op_e    alu_op,
    output v33_pkg::word_t      alu_a,
    output v33_pkg::word_t      alu_b,
    output v33_pkg::flags_t     flags,
    output v33_pkg::mem_cmd_t   mem_cmd,
    output logic                mem_req,
    output logic                halted
);

    typedef enum logic [2:0] {DECODE, EXECUTE, STORE, STR_READ, STR_WRITE} state_e;

    state_e           state;
    v33_pkg::word_t   pc;
    v33_pkg::decode_t instr;
    logic             rep_active;
    logic             more_elems;

    // Odd condition codes negate the even ones
    function automatic logic cond_true(input logic [3:0] cond, input v33_pkg::flags_t f);
        logic res;
        case (cond[3:1])
            3'd0:    res = f.v;
            3'd1:    res = f.cy;
            3'd2:    res = f.z;
            3'd3:    res = f.cy | f.z;
            3'd4:    res = f.s;
            3'd5:    res = f.p;
            3'd6:    res = f.s ^ f.v;
            default: res = (f.s ^ f.v) | f.z;
        endcase
        return res ^ cond[0];
    endfunction

    assign fetch_addr = pc;
    assign rd_a_sel   = instr.reg0;
    assign rd_b_sel   = instr.reg1;
    assign alu_op     = instr.alu_op;
    assign alu_a      = rd_a;
    assign alu_b      = rd_b;
    assign more_elems = rep_active && (cw != 16'd1);  // CW before this element's decrement

    always_comb begin
        wr_en = 1'b0;
        wr_sel = instr.reg0;
        wr_data = instr.imm;
        step_ix = 1'b0;
        step_iy = 1'b0;
        dec_cw = 1'b0;
        case (state)
            EXECUTE: wr_en = (instr.op == v33_pkg::OP_MOV_IMM);
            STORE: begin
                wr_en = (instr.alu_op != v33_pkg::ALU_CMP);
                wr_data = alu_result;
            end
            STR_READ: begin
                if (mem_ready && instr.op == v33_pkg::OP_LDM) begin
                    wr_en = 1'b1;
                    wr_sel = v33_pkg::AW;
                    wr_data = mem_rdata;
                    step_ix = 1'b1;
                    dec_cw = rep_active;
                end
            end
            STR_WRITE: begin
                if (mem_ready) begin
                    step_iy = 1'b1;
                    step_ix = (instr.op == v33_pkg::OP_MOVBK);
                    dec_cw = rep_active;
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= DECODE;
            pc <= v33_pkg::RESET_PC;
            instr <= '0;
            flags <= '0;
            rep_active <= 1'b0;
            halted <= 1'b0;
            mem_req <= 1'b0;
            mem_cmd <= '0;
        end else begin
            mem_req <= 1'b0;
            if (!halted) begin
                case (state)
                    DECODE: begin
                        instr <= decoded;
                        pc <= pc + {14'd0, decoded.size};
                        if (instr.op != v33_pkg::OP_REP_PREFIX) begin
                            rep_active <= 1'b0;  // Previous instruction was not REP
                        end
                        state <= EXECUTE;
                    end
                    EXECUTE: begin
                        state <= DECODE;
                        case (instr.op)
                            v33_pkg::OP_ALU: state <= STORE;
                            v33_pkg::OP_B_COND: begin
                                if (cond_true(instr.cond, flags)) begin
                                    pc <= pc + instr.imm;
                                end
                            end
                            v33_pkg::OP_FLAG: begin
                                case (instr.flag_action)
                                    v33_pkg::FLAG_CLR_CY:  flags.cy <= 1'b0;
                                    v33_pkg::FLAG_SET_CY:  flags.cy <= 1'b1;
                                    v33_pkg::FLAG_CLR_DIR: flags.dir <= 1'b0;
                                    default:               flags.dir <= 1'b1;
                                endcase
                            end
                            v33_pkg::OP_REP_PREFIX: rep_active <= 1'b1;
                            v33_pkg::OP_HALT: halted <= 1'b1;
                            v33_pkg::OP_STM, v33_pkg::OP_LDM, v33_pkg::OP_MOVBK: begin
                                // REP with CW of zero skips the instruction
                                if (!rep_active || cw != 16'd0) begin
                                    mem_req <= 1'b1;
                                    if (instr.op == v33_pkg::OP_STM) begin
                                        mem_cmd <= '{addr: iy, wdata: aw, write: 1'b1};
                                        state <= STR_WRITE;
                                    end else begin
                                        mem_cmd <= '{addr: ix, wdata: '0, write: 1'b0};
                                        state <= STR_READ;
                                    end
                                end
                            end
                            default: begin
                            end
                        endcase
                    end
                    STORE: begin
                        flags <= alu_flags;
                        state <= DECODE;
                    end
                    STR_READ: begin
                        if (mem_ready) begin
                            if (instr.op == v33_pkg::OP_MOVBK) begin
                                mem_req <= 1'b1;  // Read data goes straight out
                                mem_cmd <= '{addr: iy, wdata: mem_rdata, write: 1'b1};
                                state <= STR_WRITE;
                            end else begin
                                state <= more_elems ? EXECUTE : DECODE;
                            end
                        end
                    end
                    STR_WRITE: begin
                        if (mem_ready) begin
                            state <= more_elems ? EXECUTE : DECODE;
                        end
                    end
                    default: state <= DECODE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  v33_pkg::alu_op_e op,
    input  v33_pkg::word_t   a,
    input  v33_pkg::word_t   b,
    input  v33_pkg::flags_t  flags_in,
    output v33_pkg::word_t   result,
    output v33_pkg::flags_t  flags
);

    logic [16:0] wide;  // Bit 16 is carry or borrow
    logic        overflow;

    always_comb begin
        wide = {1'b0, a};
        overflow = 1'b0;
        case (op)
            v33_pkg::ALU_ADD: begin
                wide = {1'b0, a} + {1'b0, b};
                overflow = (a[15] == b[15]) && (wide[15] != a[15]);
            end
            v33_pkg::ALU_SUB, v33_pkg::ALU_CMP: begin
                wide = {1'b0, a} - {1'b0, b};
                overflow = (a[15] != b[15]) && (wide[15] != a[15]);
            end
            v33_pkg::ALU_AND: begin
                wide = {1'b0, a & b};
            end
            v33_pkg::ALU_OR: begin
                wide = {1'b0, a | b};
            end
            v33_pkg::ALU_XOR: begin
                wide = {1'b0, a ^ b};
            end
            default: begin
            end
        endcase
    end

    assign result = wide[15:0];

    // P is even parity of the low byte
    assign flags = '{
        cy:  wide[16],
        p:   ~^wide[7:0],
        z:   (wide[15:0] == 16'd0),
        s:   wide[15],
        v:   overflow,
        dir: flags_in.dir
    };

endmodule

`default_nettype wire

// ==== hdl/instr_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_decode (
    input  logic [v33_pkg::FETCH_BYTES*8-1:0] fetch_bytes,
    output v33_pkg::decode_t                  decoded
);

    logic [7:0] opcode;
    logic [7:0] modrm;
    logic [7:0] byte2;

    assign opcode = fetch_bytes[7:0];
    assign modrm  = fetch_bytes[15:8];
    assign byte2  = fetch_bytes[23:16];

    always_comb begin
        decoded = '0;
        decoded.op = v33_pkg::OP_NOP;
        decoded.size = 2'd1;
        decoded.alu_op = v33_pkg::ALU_ADD;
        decoded.reg0 = v33_pkg::reg_index_e'(modrm[5:3]);
        decoded.reg1 = v33_pkg::reg_index_e'(modrm[2:0]);
        decoded.imm = {byte2, modrm};
        decoded.cond = opcode[3:0];
        decoded.flag_action = v33_pkg::flag_action_e'({opcode[2], opcode[0]});

        casez (opcode)
            8'b1011_1???: begin  // MOV reg, imm16
                decoded.op = v33_pkg::OP_MOV_IMM;
                decoded.reg0 = v33_pkg::reg_index_e'(opcode[2:0]);
                decoded.size = 2'd3;
            end
            8'h03, 8'h0B, 8'h23, 8'h2B, 8'h33, 8'h3B: begin
                decoded.op = v33_pkg::OP_ALU;
                decoded.size = 2'd2;
                // Operation sits in opcode bits 5:3
                case (opcode[5:3])
                    3'b000:  decoded.alu_op = v33_pkg::ALU_ADD;
                    3'b001:  decoded.alu_op = v33_pkg::ALU_OR;
                    3'b100:  decoded.alu_op = v33_pkg::ALU_AND;
                    3'b101:  decoded.alu_op = v33_pkg::ALU_SUB;
                    3'b110:  decoded.alu_op = v33_pkg::ALU_XOR;
                    default: decoded.alu_op = v33_pkg::ALU_CMP;
                endcase
            end
            8'b0111_????: begin
                decoded.op = v33_pkg::OP_B_COND;
                decoded.imm = {{8{modrm[7]}}, modrm};  // rel8
                decoded.size = 2'd2;
            end
            8'hF8, 8'hF9, 8'hFC, 8'hFD: begin
                decoded.op = v33_pkg::OP_FLAG;
            end
            8'hF2, 8'hF3: begin  // REPZ and REPNZ behave alike here
                decoded.op = v33_pkg::OP_REP_PREFIX;
            end
            8'hAB: begin
                decoded.op = v33_pkg::OP_STM;
            end
            8'hAD: begin
                decoded.op = v33_pkg::OP_LDM;
            end
            8'hA5: begin
                decoded.op = v33_pkg::OP_MOVBK;
            end
            8'hF4: begin
                decoded.op = v33_pkg::OP_HALT;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module register_file (
    input  logic                clk,
    input  logic                reset,
    input  v33_pkg::reg_index_e rd_a_sel,
    input  v33_pkg::reg_index_e rd_b_sel,
    input  logic                wr_en,
    input  v33_pkg::reg_index_e wr_sel,
    input  v33_pkg::word_t      wr_data,
    input  logic                step_ix,
    input  logic                step_iy,
    input  logic                dec_cw,
    input  logic                dir,
    output v33_pkg::word_t      rd_a,
    output v33_pkg::word_t      rd_b,
    output v33_pkg::word_t      aw,
    output v33_pkg::word_t      cw,
    output v33_pkg::word_t      ix,
    output v33_pkg::word_t      iy
);

    v33_pkg::word_t regs [8];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (step_ix) begin
                regs[v33_pkg::IX] <= dir ? regs[v33_pkg::IX] - v33_pkg::STRING_STEP
                                         : regs[v33_pkg::IX] + v33_pkg::STRING_STEP;
            end
            if (step_iy) begin
                regs[v33_pkg::IY] <= dir ? regs[v33_pkg::IY] - v33_pkg::STRING_STEP
                                         : regs[v33_pkg::IY] + v33_pkg::STRING_STEP;
            end
            if (dec_cw) begin
                regs[v33_pkg::CW] <= regs[v33_pkg::CW] - 16'd1;
            end
            if (wr_en) begin
                regs[wr_sel] <= wr_data;  // Overrides a step
            end
        end
    end

    assign rd_a = regs[rd_a_sel];
    assign rd_b = regs[rd_b_sel];
    assign aw   = regs[v33_pkg::AW];
    assign cw   = regs[v33_pkg::CW];
    assign ix   = regs[v33_pkg::IX];
    assign iy   = regs[v33_pkg::IY];

endmodule

`default_nettype wire

// ==== hdl/v33_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module v33_core (
    input  logic                              clk,
    input  logic                              reset,
    output v33_pkg::word_t                    fetch_addr,
    input  logic [v33_pkg::FETCH_BYTES*8-1:0] fetch_bytes,
    output v33_pkg::mem_cmd_t                 mem_cmd,
    output logic                              mem_req,
    input  logic                              mem_ready,
    input  v33_pkg::word_t                    mem_rdata,
    output logic                              halted
);

    v33_pkg::decode_t    decoded;
    v33_pkg::reg_index_e rd_a_sel;
    v33_pkg::reg_index_e rd_b_sel;
    v33_pkg::reg_index_e wr_sel;
    logic                wr_en;
    v33_pkg::word_t      wr_data;
    logic                step_ix;
    logic                step_iy;
    logic                dec_cw;
    v33_pkg::word_t      rd_a;
    v33_pkg::word_t      rd_b;
    v33_pkg::word_t      aw;
    v33_pkg::word_t      cw;
    v33_pkg::word_t      ix;
    v33_pkg::word_t      iy;
    v33_pkg::alu_op_e    alu_op;
    v33_pkg::word_t      alu_a;
    v33_pkg::word_t      alu_b;
    v33_pkg::word_t      alu_result;
    v33_pkg::flags_t     alu_flags;
    v33_pkg::flags_t     flags;

    instr_decode u_decode (
        .fetch_bytes (fetch_bytes),
        .decoded     (decoded)
    );

    register_file u_regs (
        .clk      (clk),
        .reset    (reset),
        .rd_a_sel (rd_a_sel),
        .rd_b_sel (rd_b_sel),
        .wr_en    (wr_en),
        .wr_sel   (wr_sel),
        .wr_data  (wr_data),
        .step_ix  (step_ix),
        .step_iy  (step_iy),
        .dec_cw   (dec_cw),
        .dir      (flags.dir),
        .rd_a     (rd_a),
        .rd_b     (rd_b),
        .aw       (aw),
        .cw       (cw),
        .ix       (ix),
        .iy       (iy)
    );

    alu u_alu (
        .op       (alu_op),
        .a        (alu_a),
        .b        (alu_b),
        .flags_in (flags),
        .result   (alu_result),
        .flags    (alu_flags)
    );

    execute_control u_exec (
        .clk        (clk),
        .reset      (reset),
        .decoded    (decoded),
        .rd_a       (rd_a),
        .rd_b       (rd_b),
        .aw         (aw),
        .cw         (cw),
        .ix         (ix),
        .iy         (iy),
        .alu_result (alu_result),
        .alu_flags  (alu_flags),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .fetch_addr (fetch_addr),
        .rd_a_sel   (rd_a_sel),
        .rd_b_sel   (rd_b_sel),
        .wr_en      (wr_en),
        .wr_sel     (wr_sel),
        .wr_data    (wr_data),
        .step_ix    (step_ix),
        .step_iy    (step_iy),
        .dec_cw     (dec_cw),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .flags      (flags),
        .mem_cmd    (mem_cmd),
        .mem_req    (mem_req),
        .halted     (halted)
    );

endmodule

`default_nettype wire

// ==== tests/cpu_model.svh ====
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// Background contents of data memory that nobody wrote yet
function automatic logic [15:0] fill_word(input logic [15:0] addr);
    return (addr * 16'h9E37) ^ {addr[7:0], addr[15:8]};
endfunction

function automatic logic cond_holds(input logic [3:0] cc, input logic cy, z, s, v, p);
    case (cc)
        4'h0: return v;
        4'h1: return !v;
        4'h2: return cy;
        4'h3: return !cy;
        4'h4: return z;
        4'h5: return !z;
        4'h6: return cy | z;
        4'h7: return !(cy | z);
        4'h8: return s;
        4'h9: return !s;
        4'hA: return p;
        4'hB: return !p;
        4'hC: return s ^ v;
        4'hD: return !(s ^ v);
        4'hE: return (s ^ v) | z;
        default: return !((s ^ v) | z);
    endcase
endfunction

function automatic logic [15:0] model_read(input logic [15:0] addr);
    if (model_mem.exists(addr)) begin
        return model_mem[addr];
    end
    return fill_word(addr);
endfunction

task automatic model_write(input logic [15:0] addr, input logic [15:0] data);
    model_mem[addr] = data;
    exp_writes.push_back({addr, data});
endtask

// Runs the program in code[] to HALT and fills exp_writes
task automatic run_model(output logic [15:0] halt_pc);
    logic [15:0] r [8];
    logic [15:0] pc;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] step;
    logic [16:0] wide;
    logic [7:0] op;
    logic [7:0] b1;
    logic [7:0] b2;
    logic cy, p, z, s, v, dir;
    logic rep;
    logic was_rep;
    logic is_alu;
    logic done;
    int count;
    int sres;
    model_mem.delete();
    exp_writes.delete();
    for (int i = 0; i < 8; i++) begin
        r[i] = 16'h0000;
    end
    pc = 16'h0000;
    {cy, p, z, s, v, dir, rep} = 7'd0;
    done = 1'b0;
    halt_pc = 16'h0000;
    for (int steps = 0; steps < 1000 && !done; steps++) begin
        op = code[pc[8:0]];
        b1 = code[pc[8:0] + 9'd1];
        b2 = code[pc[8:0] + 9'd2];
        was_rep = rep;
        rep = 1'b0;
        is_alu = 1'b0;
        step = dir ? 16'hFFFE : 16'h0002;
        a = r[b1[5:3]];
        b = r[b1[2:0]];
        casez (op)
            8'b1011_1???: begin
                r[op[2:0]] = {b2, b1};
                pc = pc + 16'd3;
            end
            8'h03: begin
                wide = {1'b0, a} + {1'b0, b};
                cy = wide[16];
                sres = int'($signed(a)) + int'($signed(b));
                v = (sres > 32767) || (sres < -32768);  // Signed result out of range
                is_alu = 1'b1;
            end
            8'h2B, 8'h3B: begin
                wide = {1'b0, a} - {1'b0, b};
                cy = (a < b);  // Borrow
                sres = int'($signed(a)) - int'($signed(b));
                v = (sres > 32767) || (sres < -32768);
                is_alu = 1'b1;
            end
            8'h23, 8'h0B, 8'h33: begin
                wide = (op == 8'h23) ? {1'b0, a & b} :
                       (op == 8'h0B) ? {1'b0, a | b} : {1'b0, a ^ b};
                cy = 1'b0;
                v = 1'b0;
                is_alu = 1'b1;
            end
            8'b0111_????: begin
                pc = pc + 16'd2;
                if (cond_holds(op[3:0], cy, z, s, v, p)) begin
                    pc = pc + {{8{b1[7]}}, b1};
                end
            end
            8'hF8, 8'hF9: begin
                cy = op[0];
                pc = pc + 16'd1;
            end
            8'hFC, 8'hFD: begin
                dir = op[0];
                pc = pc + 16'd1;
            end
            8'hF2, 8'hF3: begin
                rep = 1'b1;
                pc = pc + 16'd1;
            end
            8'hAB, 8'hAD, 8'hA5: begin
                count = was_rep ? int'(r[v33_pkg::CW]) : 1;
                for (int e = 0; e < count; e++) begin
                    if (op == 8'hAB) begin
                        model_write(r[v33_pkg::IY], r[v33_pkg::AW]);
                        r[v33_pkg::IY] = r[v33_pkg::IY] + step;
                    end else if (op == 8'hAD) begin
                        r[v33_pkg::AW] = model_read(r[v33_pkg::IX]);
                        r[v33_pkg::IX] = r[v33_pkg::IX] + step;
                    end else begin
                        model_write(r[v33_pkg::IY], model_read(r[v33_pkg::IX]));
                        r[v33_pkg::IX] = r[v33_pkg::IX] + step;
                        r[v33_pkg::IY] = r[v33_pkg::IY] + step;
                    end
                end
                if (was_rep) begin
                    r[v33_pkg::CW] = 16'h0000;
                end
                pc = pc + 16'd1;
            end
            8'hF4: begin
                halt_pc = pc + 16'd1;
                done = 1'b1;
            end
            default: pc = pc + 16'd1;
        endcase
        if (is_alu) begin
            z = (wide[15:0] == 16'h0000);
            s = wide[15];
            p = ~^wide[7:0];
            if (op != 8'h3B) begin  // CMP keeps the destination
                r[b1[5:3]] = wide[15:0];
            end
            pc = pc + 16'd2;
        end
    end
endtask

`endif

// ==== tests/tb_v33_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_v33_core;

    localparam int NUM_TESTS = 40;
    localparam int NUM_CHUNKS = 16;
    localparam int PROG_LEN = 4 * NUM_CHUNKS + 1;  // Worst case instruction count
    localparam int MAX_REP = 7;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * PROG_LEN * (MAX_REP * 2 * 5);

    logic              clk;
    logic              reset;
    v33_pkg::word_t    fetch_addr;
    logic [23:0]       fetch_bytes;
    v33_pkg::mem_cmd_t mem_cmd;
    logic              mem_req;
    logic              mem_ready;
    v33_pkg::word_t    mem_rdata;
    logic              halted;

    integer            seed;
    logic [7:0]        code [512];
    int                code_len;
    logic [15:0]       data_mem [logic [15:0]];
    logic [15:0]       model_mem [logic [15:0]];
    logic [31:0]       exp_writes [$];
    logic [31:0]       got_writes [$];
    v33_pkg::mem_cmd_t pending_cmd;
    logic              pending;
    int                wait_left;
    int                errors;
    int                failed_tests;
    logic [7:0]        alu_codes [6] = '{8'h03, 8'h2B, 8'h23, 8'h0B, 8'h33, 8'h3B};
    logic [7:0]        flag_codes [4] = '{8'hF8, 8'hF9, 8'hFC, 8'hFD};

    `include "cpu_model.svh"

    v33_core dut (
        .clk         (clk),
        .reset       (reset),
        .fetch_addr  (fetch_addr),
        .fetch_bytes (fetch_bytes),
        .mem_cmd     (mem_cmd),
        .mem_req     (mem_req),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata),
        .halted      (halted)
    );

    // Little endian code port
    assign fetch_bytes = {code[fetch_addr[8:0] + 9'd2], code[fetch_addr[8:0] + 9'd1],
                          code[fetch_addr[8:0]]};

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Data memory with 0 to 3 wait cycles per request
    always begin
        @(posedge clk);
        #2;
        mem_ready = 1'b0;
        if (reset) begin
            pending = 1'b0;
        end else begin
            if (mem_req) begin
                pending = 1'b1;
                pending_cmd = mem_cmd;
                wait_left = rand_below(4);
            end
            if (pending && wait_left == 0) begin
                if (pending_cmd.write) begin
                    data_mem[pending_cmd.addr] = pending_cmd.wdata;
                    got_writes.push_back({pending_cmd.addr, pending_cmd.wdata});
                end else if (data_mem.exists(pending_cmd.addr)) begin
                    mem_rdata = data_mem[pending_cmd.addr];
                end else begin
                    mem_rdata = fill_word(pending_cmd.addr);
                end
                pending = 1'b0;
                mem_ready = 1'b1;
            end else if (pending) begin
                wait_left--;
            end
        end
    end

    task automatic put_byte(input logic [7:0] b);
        code[code_len] = b;
        code_len = code_len + 1;
    endtask

    task automatic build_program();
        logic [15:0] imm;
        int kind;
        code_len = 0;
        for (int i = 0; i < 512; i++) begin
            code[i] = 8'hF4;
        end
        for (int c = 0; c < NUM_CHUNKS; c++) begin
            kind = rand_below(6);
            imm = 16'($random(seed));
            case (kind)
                0: begin
                    put_byte(8'(8'hB8 + rand_below(8)));
                    put_byte(imm[7:0]);
                    put_byte(imm[15:8]);
                end
                1: begin
                    put_byte(alu_codes[rand_below(6)]);
                    put_byte({2'b11, 3'(rand_below(8)), 3'(rand_below(8))});
                end
                2: put_byte(flag_codes[rand_below(4)]);
                3: begin  // Bcc over one STM
                    put_byte(8'(8'h70 + rand_below(16)));
                    put_byte(8'h01);
                    put_byte(8'hAB);
                end
                4: begin
                    put_byte(8'hB9);  // MOV CW, count
                    put_byte(8'(rand_below(MAX_REP + 1)));
                    put_byte(8'h00);
                    put_byte(rand_below(2) ? 8'hF3 : 8'hF2);
                    kind = rand_below(3);
                    if (kind == 0) begin
                        put_byte(8'hAB);
                    end else if (kind == 1) begin
                        put_byte(8'hAD);
                        put_byte(8'hAB);  // Makes the loaded word visible
                    end else begin
                        put_byte(8'hA5);
                    end
                end
                default: put_byte(8'hAB);
            endcase
        end
        put_byte(8'hF4);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic run_test(input int t);
        logic [15:0] halt_pc;
        int errors_before;
        int extra_reqs;
        int n;
        errors_before = errors;
        @(posedge clk);
        #2;
        reset = 1'b1;
        build_program();
        run_model(halt_pc);
        repeat (2) @(posedge clk);
        #2;
        data_mem.delete();
        got_writes.delete();
        check_value($sformatf("test %0d reset mem_req", t), 0, mem_req);
        check_value($sformatf("test %0d reset halted", t), 0, halted);
        check_value($sformatf("test %0d reset fetch_addr", t), 0, fetch_addr);
        reset = 1'b0;
        while (!halted) begin
            @(posedge clk);
            #2;
        end
        check_value($sformatf("test %0d halt pc", t), halt_pc, fetch_addr);
        extra_reqs = 0;
        repeat (20) begin
            @(posedge clk);
            #2;
            if (mem_req) begin
                extra_reqs++;
            end
        end
        check_value($sformatf("test %0d requests after halt", t), 0, extra_reqs);
        check_value($sformatf("test %0d write count", t), exp_writes.size(), got_writes.size());
        n = (exp_writes.size() < got_writes.size()) ? exp_writes.size() : got_writes.size();
        for (int i = 0; i < n; i++) begin
            check_value($sformatf("test %0d write %0d", t, i), exp_writes[i], got_writes[i]);
        end
        if (errors == errors_before) begin
            $display("test %0d ok, %0d writes", t, got_writes.size());
        end else begin
            failed_tests++;
            $display("test %0d failed, %0d check errors", t, errors - errors_before);
        end
    endtask

    initial begin
        seed = 18533;
        reset = 1'b1;
        mem_ready = 1'b0;
        mem_rdata = 16'h0000;
        pending = 1'b0;
        wait_left = 0;
        errors = 0;
        failed_tests = 0;
        code_len = 0;
        for (int i = 0; i < 512; i++) begin
            code[i] = 8'hF4;
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 NUM_TESTS, failed_tests, errors, dut.props.failures);
        if (errors == 0 && dut.props.failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the DUT did not halt in time",
                 WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/v33_core_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module v33_core_properties (
    input logic              clk,
    input logic              reset,
    input v33_pkg::mem_cmd_t mem_cmd,
    input logic              mem_req,
    input logic              mem_ready,
    input logic              halted
);

    logic busy;  // Request issued and not yet completed
    int   failures = 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (mem_req && !mem_ready) begin
            busy <= 1'b1;
        end else if (busy && mem_ready) begin
            busy <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (reset) busy |-> !mem_req) else begin
        $error("mem_req raised while a request is outstanding");
        failures++;
    end

    assert property (@(posedge clk) disable iff (reset) busy |-> $stable(mem_cmd)) else begin
        $error("mem_cmd changed while a request is outstanding");
        failures++;
    end

    assert property (@(posedge clk) disable iff (reset) $past(halted) |-> halted) else begin
        $error("halted fell without reset");
        failures++;
    end

    assert property (@(posedge clk) disable iff (reset) halted |-> !mem_req) else begin
        $error("mem_req raised while halted");
        failures++;
    end

endmodule

bind v33_core v33_core_properties props (
    .clk       (clk),
    .reset     (reset),
    .mem_cmd   (mem_cmd),
    .mem_req   (mem_req),
    .mem_ready (mem_ready),
    .halted    (halted)
);

`default_nettype wire

// ==== v33_core.f ====
+incdir+tests
common/v33_pkg.sv
hdl/instr_decode.sv
hdl/register_file.sv
hdl/alu.sv
execute/execute_control.sv
hdl/v33_core.sv
tests/v33_core_properties.sv
tests/tb_v33_core.sv
